//--- filelist.f
+incdir+logic
logic/fifo_pkg.sv
logic/arb_pkg.sv
logic/fifo_w1r1.sv
logic/rr_arbiter.sv
logic/merge_top.sv
tests/merge_tb.sv

//--- Makefile
# Verilator build and run for the two-channel merge unit.

TOOL     = verilator
FLAGS    = --binary --timing
TOP      = merge_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove build output and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "tests failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/merge_tb.sv
// Directed tests of merge_top; expects MERGE_FIFO_DEPTH of at least 2 and a single-cycle flush.
`default_nettype none

`include "merge_defines.svh"

module merge_tb;

  localparam int WAIT_LIMIT = 100;
  localparam int DEPTH      = `MERGE_FIFO_DEPTH;

  logic               i_clk;
  logic               i_rst_n;
  logic               i_cg;
  logic               i_flush;
  fifo_pkg::data_t    i_data_a;
  logic               i_valid_a;
  logic               o_ready_a;
  fifo_pkg::data_t    i_data_b;
  logic               i_valid_b;
  logic               o_ready_b;
  fifo_pkg::data_t    o_data;
  arb_pkg::src_t      o_src;
  logic               o_valid;
  logic               i_ready;
  fifo_pkg::count_t   o_level_a;
  fifo_pkg::count_t   o_level_b;

  // Words each channel has accepted but not yet delivered.
  fifo_pkg::data_t    exp_a [$];
  fifo_pkg::data_t    exp_b [$];
  // Tags of delivered words, in delivery order.
  arb_pkg::src_t      tag_log [$];

  logic [31:0]        lcg_state = 32'ha9d3_2a10;
  string              cur_test = "reset";
  int                 err_count = 0;
  int                 timeout_count = 0;

  merge_top merge_top_i (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_cg      (i_cg),
    .i_flush   (i_flush),
    .i_data_a  (i_data_a),
    .i_valid_a (i_valid_a),
    .o_ready_a (o_ready_a),
    .i_data_b  (i_data_b),
    .i_valid_b (i_valid_b),
    .o_ready_b (o_ready_b),
    .o_data    (o_data),
    .o_src     (o_src),
    .o_valid   (o_valid),
    .i_ready   (i_ready),
    .o_level_a (o_level_a),
    .o_level_b (o_level_b)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  function automatic fifo_pkg::data_t rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return fifo_pkg::data_t'(lcg_state[23:16]);
  endfunction

  task automatic check_data(input string what, input fifo_pkg::data_t exp,
                            input fifo_pkg::data_t act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_src(input string what, input arb_pkg::src_t exp,
                           input arb_pkg::src_t act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %b, actual %b", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_count(input string what, input fifo_pkg::count_t exp,
                             input fifo_pkg::count_t act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %b, actual %b", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Error: %s gave up waiting for %s after %0d cycles", cur_test, what, WAIT_LIMIT);
    err_count++;
    timeout_count++;
  endtask

  // Delivered word goes against the queue of the channel it is tagged with.
  task automatic check_output();
    fifo_pkg::data_t exp;
    tag_log.push_back(o_src);
    if (o_src == 1'b0) begin
      if (exp_a.size() == 0) begin
        $display("Error: %s word %h arrived tagged A with nothing pending on A",
                 cur_test, o_data);
        err_count++;
      end else begin
        exp = exp_a.pop_front();
        check_data("data from A", exp, o_data);
      end
    end else begin
      if (exp_b.size() == 0) begin
        $display("Error: %s word %h arrived tagged B with nothing pending on B",
                 cur_test, o_data);
        err_count++;
      end else begin
        exp = exp_b.pop_front();
        check_data("data from B", exp, o_data);
      end
    end
  endtask

  // Handshakes seen here complete on the following rising edge.
  always @(negedge i_clk) begin
    if (i_rst_n && i_cg && !i_flush) begin
      if (i_valid_a && o_ready_a) begin
        exp_a.push_back(i_data_a);
      end
      if (i_valid_b && o_ready_b) begin
        exp_b.push_back(i_data_b);
      end
      if (o_valid && i_ready) begin
        check_output();
      end
    end
  end

  // Offer tasks return with the transfer pending on the next edge.
  // A single-channel offer withdraws the other producer.
  task automatic offer_a(input fifo_pkg::data_t word);
    int waited;
    waited = 0;
    @(posedge i_clk);
    i_valid_a <= 1'b1;
    i_data_a  <= word;
    i_valid_b <= 1'b0;
    @(negedge i_clk);
    while (!o_ready_a && waited < WAIT_LIMIT) begin
      @(negedge i_clk);
      waited++;
    end
    if (!o_ready_a) begin
      report_timeout("o_ready_a");
    end
  endtask

  task automatic offer_b(input fifo_pkg::data_t word);
    int waited;
    waited = 0;
    @(posedge i_clk);
    i_valid_b <= 1'b1;
    i_data_b  <= word;
    i_valid_a <= 1'b0;
    @(negedge i_clk);
    while (!o_ready_b && waited < WAIT_LIMIT) begin
      @(negedge i_clk);
      waited++;
    end
    if (!o_ready_b) begin
      report_timeout("o_ready_b");
    end
  endtask

  task automatic offer_both(input fifo_pkg::data_t word_a, input fifo_pkg::data_t word_b);
    int waited;
    waited = 0;
    @(posedge i_clk);
    i_valid_a <= 1'b1;
    i_data_a  <= word_a;
    i_valid_b <= 1'b1;
    i_data_b  <= word_b;
    @(negedge i_clk);
    while (!(o_ready_a && o_ready_b) && waited < WAIT_LIMIT) begin
      @(negedge i_clk);
      waited++;
    end
    if (!(o_ready_a && o_ready_b)) begin
      report_timeout("both producer handshakes");
    end
  endtask

  task automatic release_inputs();
    @(posedge i_clk);
    i_valid_a <= 1'b0;
    i_valid_b <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(posedge i_clk);
    while ((exp_a.size() != 0 || exp_b.size() != 0) && waited < WAIT_LIMIT) begin
      @(posedge i_clk);
      waited++;
    end
    if (exp_a.size() != 0 || exp_b.size() != 0) begin
      $display("Error: %s output stalled with %0d A and %0d B words never delivered",
               cur_test, exp_a.size(), exp_b.size());
      err_count++;
      timeout_count++;
      exp_a.delete();
      exp_b.delete();
    end
  endtask

  task automatic wait_valid();
    int waited;
    waited = 0;
    @(negedge i_clk);
    while (!o_valid && waited < WAIT_LIMIT) begin
      @(negedge i_clk);
      waited++;
    end
    if (!o_valid) begin
      report_timeout("o_valid");
    end
  endtask

  task automatic check_idle();
    @(negedge i_clk);
    check_flag("o_valid idle", 1'b0, o_valid);
    check_count("level A idle", '0, o_level_a);
    check_count("level B idle", '0, o_level_b);
  endtask

  task automatic test_reset_state();
    cur_test = "reset_state";
    @(negedge i_clk);
    check_flag("o_valid", 1'b0, o_valid);
    check_flag("o_ready_a", 1'b1, o_ready_a);
    check_flag("o_ready_b", 1'b1, o_ready_b);
    check_count("level A", '0, o_level_a);
    check_count("level B", '0, o_level_b);
  endtask

  // Twelve words per channel wrap the five-entry pointers twice.
  task automatic test_single_channel();
    cur_test = "single_a";
    @(posedge i_clk);
    i_ready <= 1'b1;
    for (int i = 0; i < 12; i++) begin
      offer_a(rand_word());
    end
    release_inputs();
    wait_drain();
    check_idle();
    cur_test = "single_b";
    for (int i = 0; i < 12; i++) begin
      offer_b(rand_word());
    end
    release_inputs();
    wait_drain();
    check_idle();
  endtask

  // One word sits in the output register, the rest fill FIFO A.
  task automatic test_back_pressure();
    cur_test = "back_pressure";
    @(posedge i_clk);
    i_ready <= 1'b0;
    for (int i = 0; i < DEPTH + 1; i++) begin
      offer_a(rand_word());
    end
    @(posedge i_clk);
    i_data_a <= rand_word();
    repeat (4) begin
      @(negedge i_clk);
      check_flag("o_ready_a when full", 1'b0, o_ready_a);
    end
    check_count("level A when full", fifo_pkg::count_t'(DEPTH), o_level_a);
    check_flag("o_valid when full", 1'b1, o_valid);
    release_inputs();
    i_ready <= 1'b1;
    wait_drain();
    check_idle();
  endtask

  task automatic test_fairness();
    cur_test = "fairness";
    @(posedge i_clk);
    i_ready <= 1'b0;
    for (int i = 0; i < 4; i++) begin
      offer_both(rand_word(), rand_word());
    end
    release_inputs();
    tag_log.delete();
    repeat (3) @(posedge i_clk);
    i_ready <= 1'b1;
    wait_drain();
    if (tag_log.size() != 8) begin
      $display("Fail %s delivered words: expected 8, actual %0d", cur_test, tag_log.size());
      err_count++;
    end
    for (int i = 1; i < tag_log.size(); i++) begin
      check_src("alternating tag", arb_pkg::src_t'(!tag_log[i - 1]), tag_log[i]);
    end
    check_idle();
  endtask

  task automatic test_flush();
    cur_test = "flush";
    @(posedge i_clk);
    i_ready <= 1'b0;
    offer_both(rand_word(), rand_word());
    offer_both(rand_word(), rand_word());
    offer_a(rand_word());
    release_inputs();
    repeat (2) @(posedge i_clk);
    i_flush <= 1'b1;
    @(posedge i_clk);
    i_flush <= 1'b0;
    // Every pending word is gone after the flush edge.
    exp_a.delete();
    exp_b.delete();
    check_idle();
    for (int i = 0; i < 4; i++) begin
      offer_a(rand_word());
    end
    for (int i = 0; i < 3; i++) begin
      offer_b(rand_word());
    end
    release_inputs();
    i_ready <= 1'b1;
    wait_drain();
    repeat (3) check_idle();
  endtask

  task automatic test_clock_enable();
    fifo_pkg::data_t  held_data;
    arb_pkg::src_t    held_src;
    fifo_pkg::count_t held_a;
    fifo_pkg::count_t held_b;
    cur_test = "clock_enable";
    @(posedge i_clk);
    i_ready <= 1'b0;
    offer_a(rand_word());
    offer_a(rand_word());
    offer_b(rand_word());
    release_inputs();
    wait_valid();
    repeat (2) @(negedge i_clk);
    held_data = o_data;
    held_src  = o_src;
    held_a    = o_level_a;
    held_b    = o_level_b;
    // Offer words and accept output while frozen.
    @(posedge i_clk);
    i_cg      <= 1'b0;
    i_ready   <= 1'b1;
    i_valid_a <= 1'b1;
    i_data_a  <= rand_word();
    i_valid_b <= 1'b1;
    i_data_b  <= rand_word();
    repeat (5) begin
      @(negedge i_clk);
      check_flag("o_ready_a frozen", 1'b0, o_ready_a);
      check_flag("o_ready_b frozen", 1'b0, o_ready_b);
      check_flag("o_valid frozen", 1'b1, o_valid);
      check_data("o_data frozen", held_data, o_data);
      check_src("o_src frozen", held_src, o_src);
      check_count("level A frozen", held_a, o_level_a);
      check_count("level B frozen", held_b, o_level_b);
    end
    @(posedge i_clk);
    i_cg      <= 1'b1;
    i_valid_a <= 1'b0;
    i_valid_b <= 1'b0;
    wait_drain();
    offer_both(rand_word(), rand_word());
    offer_a(rand_word());
    release_inputs();
    wait_drain();
    check_idle();
  endtask

  initial begin
    i_rst_n   = 1'b0;
    i_cg      = 1'b1;
    i_flush   = 1'b0;
    i_data_a  = '0;
    i_valid_a = 1'b0;
    i_data_b  = '0;
    i_valid_b = 1'b0;
    i_ready   = 1'b0;
    repeat (16) @(posedge i_clk);
    i_rst_n <= 1'b1;

    test_reset_state();
    test_single_channel();
    test_back_pressure();
    test_fairness();
    test_flush();
    test_clock_enable();

    repeat (2) @(posedge i_clk);
    $display("Summary: %0d errors, %0d of them timeouts", err_count, timeout_count);
    if (err_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/merge_top.sv
// Two producers merged onto one tagged output; channel A stores in memory and channel B in flops.
`default_nettype none

module merge_top (
  input  wire                  i_clk,
  input  wire                  i_rst_n,
  input  wire                  i_cg,
  input  wire                  i_flush,

  input  wire fifo_pkg::data_t i_data_a,
  input  wire                  i_valid_a,
  output logic                 o_ready_a,

  input  wire fifo_pkg::data_t i_data_b,
  input  wire                  i_valid_b,
  output logic                 o_ready_b,

  output fifo_pkg::data_t      o_data,
  output arb_pkg::src_t        o_src,
  output logic                 o_valid,
  input  wire                  i_ready,

  output fifo_pkg::count_t     o_level_a,
  output fifo_pkg::count_t     o_level_b
);

  // FIFO heads toward the arbiter.
  fifo_pkg::data_t head_data_a;
  fifo_pkg::data_t head_data_b;
  logic            head_valid_a;
  logic            head_valid_b;
  logic            head_ready_a;
  logic            head_ready_b;

  // Channel A keeps its words in a memory array.
  fifo_w1r1 #(
    .FLOPS_NOT_MEM (1'b0)
  ) fifo_a_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_cg    (i_cg),
    .i_flush (i_flush),
    .i_data  (i_data_a),
    .i_valid (i_valid_a),
    .o_ready (o_ready_a),
    .o_data  (head_data_a),
    .o_valid (head_valid_a),
    .i_ready (head_ready_a),
    .o_count (o_level_a)
  );

  // Channel B keeps its words in reset flops.
  fifo_w1r1 #(
    .FLOPS_NOT_MEM (1'b1)
  ) fifo_b_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_cg    (i_cg),
    .i_flush (i_flush),
    .i_data  (i_data_b),
    .i_valid (i_valid_b),
    .o_ready (o_ready_b),
    .o_data  (head_data_b),
    .o_valid (head_valid_b),
    .i_ready (head_ready_b),
    .o_count (o_level_b)
  );

  rr_arbiter arb_i (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_cg      (i_cg),
    .i_flush   (i_flush),
    .i_data_a  (head_data_a),
    .i_valid_a (head_valid_a),
    .o_ready_a (head_ready_a),
    .i_data_b  (head_data_b),
    .i_valid_b (head_valid_b),
    .o_ready_b (head_ready_b),
    .o_data    (o_data),
    .o_src     (o_src),
    .o_valid   (o_valid),
    .i_ready   (i_ready)
  );

endmodule

`default_nettype wire

//--- logic/rr_arbiter.sv
// Serves exactly two FIFO heads into a one-word output register; no locking or priorities.
`default_nettype none

module rr_arbiter (
  input  wire                  i_clk,
  input  wire                  i_rst_n,
  input  wire                  i_cg,
  input  wire                  i_flush,

  input  wire fifo_pkg::data_t i_data_a,
  input  wire                  i_valid_a,
  output logic                 o_ready_a,

  input  wire fifo_pkg::data_t i_data_b,
  input  wire                  i_valid_b,
  output logic                 o_ready_b,

  output fifo_pkg::data_t      o_data,
  output arb_pkg::src_t        o_src,
  output logic                 o_valid,
  input  wire                  i_ready
);

  arb_pkg::arb_pref_e pref_q;
  logic               valid_q;
  fifo_pkg::data_t    data_q;
  arb_pkg::src_t      src_q;

  logic slot_free;
  logic drain;
  logic grant_a;
  logic grant_b;

  // The slot can take a word when empty or when its word leaves this cycle.
  assign drain     = i_cg && valid_q && i_ready;
  assign slot_free = i_cg && !i_flush && (!valid_q || i_ready);

  // A lone valid head always wins. With both valid the preference decides.
  assign grant_a = slot_free && i_valid_a && (!i_valid_b || (pref_q == arb_pkg::PREFER_A));
  assign grant_b = slot_free && i_valid_b && (!i_valid_a || (pref_q == arb_pkg::PREFER_B));

  // Ready pops the FIFO head only in the capture cycle.
  assign o_ready_a = grant_a;
  assign o_ready_b = grant_b;

  assign o_valid = valid_q;
  assign o_data  = data_q;
  assign o_src   = src_q;

  // Slot occupancy and round-robin state.
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
      pref_q  <= arb_pkg::PREFER_A;
    end else if (i_cg) begin
      if (i_flush) begin
        valid_q <= 1'b0;
      end else if (grant_a || grant_b) begin
        valid_q <= 1'b1;
        // The winner hands the next tie to the other channel.
        pref_q  <= grant_a ? arb_pkg::PREFER_B : arb_pkg::PREFER_A;
      end else if (drain) begin
        valid_q <= 1'b0;
      end
    end
  end

  // Captured word and its source tag.
  always_ff @(posedge i_clk) begin
    if (grant_a || grant_b) begin
      data_q <= grant_a ? i_data_a : i_data_b;
      src_q  <= arb_pkg::src_t'(grant_b);
    end
  end

endmodule

`default_nettype wire

//--- logic/fifo_w1r1.sv
// Depth comes from MERGE_FIFO_DEPTH and may be any value of two or more; i_cg low freezes all state.
`default_nettype none

`include "merge_defines.svh"

module fifo_w1r1 #(
  parameter bit FLOPS_NOT_MEM = 1'b0
) (
  input  wire                    i_clk,
  input  wire                    i_rst_n,
  input  wire                    i_cg,
  input  wire                    i_flush,

  input  wire fifo_pkg::data_t   i_data,
  input  wire                    i_valid,
  output logic                   o_ready,

  output fifo_pkg::data_t        o_data,
  output logic                   o_valid,
  input  wire                    i_ready,

  output fifo_pkg::count_t       o_count
);

  localparam fifo_pkg::ptr_t   LAST_PTR   = fifo_pkg::ptr_t'(`MERGE_FIFO_DEPTH - 1);
  localparam fifo_pkg::count_t FULL_COUNT = fifo_pkg::count_t'(`MERGE_FIFO_DEPTH);

  fifo_pkg::data_t  mem [`MERGE_FIFO_DEPTH];
  fifo_pkg::ptr_t   wptr_q;
  fifo_pkg::ptr_t   rptr_q;
  fifo_pkg::count_t count_q;

  logic full;
  logic push;
  logic pop;

  // Advance a pointer and wrap at the last entry.
  function automatic fifo_pkg::ptr_t next_ptr(input fifo_pkg::ptr_t ptr);
    if (ptr == LAST_PTR) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Full and empty both come from the fill count.
  assign full    = (count_q == FULL_COUNT);
  assign o_valid = (count_q != '0);

  // A full FIFO still accepts a word when its head leaves in the same cycle.
  assign o_ready = i_cg && (!full || i_ready);

  assign push = i_valid && o_ready;
  assign pop  = i_cg && o_valid && i_ready;

  // Head word is always visible at the read pointer.
  assign o_data  = mem[rptr_q];
  assign o_count = count_q;

  // Pointers and fill count.
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (i_cg) begin
      if (i_flush) begin
        wptr_q  <= '0;
        rptr_q  <= '0;
        count_q <= '0;
      end else begin
        if (push) begin
          wptr_q <= next_ptr(wptr_q);
        end
        if (pop) begin
          rptr_q <= next_ptr(rptr_q);
        end
        case ({push, pop})
          2'b10:   count_q <= count_q + 1'b1;
          2'b01:   count_q <= count_q - 1'b1;
          default: count_q <= count_q;
        endcase
      end
    end
  end

  // Storage style is chosen per instance.
  generate
    if (FLOPS_NOT_MEM) begin : g_flops
      // Flip-flop storage clears on reset and on flush.
      always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
          for (int i = 0; i < `MERGE_FIFO_DEPTH; i++) begin
            mem[i] <= '0;
          end
        end else if (i_cg) begin
          if (i_flush) begin
            for (int i = 0; i < `MERGE_FIFO_DEPTH; i++) begin
              mem[i] <= '0;
            end
          end else if (push) begin
            mem[wptr_q] <= i_data;
          end
        end
      end
    end else begin : g_mem
      // Plain array that maps onto a memory block.
      // Only the pointers and count decide which entries are live.
      always_ff @(posedge i_clk) begin
        if (push && !i_flush) begin
          mem[wptr_q] <= i_data;
        end
      end
    end
  endgenerate

endmodule

`default_nettype wire

//--- logic/arb_pkg.sv
// Arbiter-side types for a fixed pair of channels; a third source would need a wider tag.
`default_nettype none

`include "merge_defines.svh"

package arb_pkg;

  // Source tag carried beside each output word.
  // Zero marks channel A and one marks channel B.
  typedef logic src_t;

  // Which channel wins when both heads are valid.
  typedef enum logic {
    PREFER_A = 1'b0,
    PREFER_B = 1'b1
  } arb_pref_e;

endpackage

`default_nettype wire

//--- logic/fifo_pkg.sv
// FIFO-side types whose widths follow MERGE_DATA_W and MERGE_FIFO_DEPTH from the defines header.
`default_nettype none

`include "merge_defines.svh"

package fifo_pkg;

  // One payload word as pushed by a producer.
  typedef logic [`MERGE_DATA_W-1:0] data_t;

  // Storage index from zero to MERGE_FIFO_DEPTH minus one.
  typedef logic [$clog2(`MERGE_FIFO_DEPTH)-1:0] ptr_t;

  // Fill level from zero up to MERGE_FIFO_DEPTH inclusive.
  typedef logic [$clog2(`MERGE_FIFO_DEPTH + 1)-1:0] count_t;

endpackage

`default_nettype wire

//--- logic/merge_defines.svh
// Global sizes shared by both packages and the RTL; changing them resizes every typedef.
`ifndef MERGE_DEFINES_SVH
`define MERGE_DEFINES_SVH

// Width of one data word in bits.
`define MERGE_DATA_W 8

// Entries held by each channel FIFO.
// Five is not a power of two, so the pointers wrap explicitly.
`define MERGE_FIFO_DEPTH 5

`endif
